// File: branch_pred.f
hdl/bp_isa_pkg.sv
hdl/bp_cfg_pkg.sv
hdl/bp_ifs.sv
hdl/tournament_dir.sv
hdl/return_stack.sv
hdl/jalr_btb.sv
hdl/next_pc_select.sv
hdl/branch_pred.sv
tests/tb_clk_gen.sv
tests/branch_pred_assertions.sv
tests/tb_branch_pred.sv

// File: Makefile
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing --assert
TOP       := tb_branch_pred
FILELIST  := branch_pred.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_branch_pred.sv
`timescale 1ns/100ps
`default_nettype none

module tb_branch_pred;
    localparam int IDX_W         = 10;
    localparam int RAS_DEPTH     = 8;
    localparam int SP_W          = $clog2(RAS_DEPTH);
    localparam int RESET_TIMEOUT = 20;

    // encodings the predictor itself does not name
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_ALU    = 7'b0110011;
    localparam logic [2:0] TYPE_OTHER = 3'b000;

    logic                              clk;
    logic                              rst;
    logic                              fetch_valid_i;
    bp_isa_pkg::addr_t                 fetch_pc_i;
    bp_isa_pkg::addr_t                 fetch_seq_pc_i;
    logic [6:0]                        fetch_opcode_i;
    logic [4:0]                        fetch_rd_i;
    logic [4:0]                        fetch_rs1_i;
    logic [2:0]                        fetch_type_i;
    logic [31:0]                       fetch_imm_i;
    logic                              pred_is_jump_o;
    logic                              pred_taken_o;
    bp_isa_pkg::addr_t                 pred_pc_o;
    logic [IDX_W-1:0]                  snap_ghr_o;
    logic [IDX_W-1:0]                  snap_lht_o;
    logic                              snap_gshare_taken_o;
    logic                              snap_local_taken_o;
    logic [SP_W-1:0]                   snap_ras_sp_o;
    bp_isa_pkg::addr_t [RAS_DEPTH-1:0] snap_ras_o;
    logic                              ex_valid_i;
    logic                              ex_is_jump_i;
    logic                              ex_is_cond_br_i;
    logic                              ex_is_jalr_i;
    logic                              ex_taken_i;
    logic                              ex_pred_correct_i;
    bp_isa_pkg::addr_t                 ex_pc_i;
    bp_isa_pkg::addr_t                 ex_target_i;
    logic [IDX_W-1:0]                  ex_ghr_i;
    logic [IDX_W-1:0]                  ex_lht_i;
    logic                              ex_gshare_taken_i;
    logic                              ex_local_taken_i;
    logic [SP_W-1:0]                   ex_ras_sp_i;
    bp_isa_pkg::addr_t [RAS_DEPTH-1:0] ex_ras_i;

    int error_count;
    int seed;

    tb_clk_gen tb_clk_gen_inst (.clk(clk), .rst(rst));

    branch_pred #(.IDX_W(IDX_W), .RAS_DEPTH(RAS_DEPTH)) branch_pred_inst (.*);

    task automatic check_value(input string name, input logic [255:0] got,
                               input logic [255:0] exp);
        assert (got == exp) else begin
            error_count++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    function automatic logic [IDX_W-1:0] shift_hist(input logic [IDX_W-1:0] h, input logic b);
        return {h[IDX_W-2:0], b};
    endfunction

    task automatic idle_fetch();
        fetch_valid_i  = 1'b0;
        fetch_pc_i     = 32'h800;
        fetch_seq_pc_i = 32'h804;
        fetch_opcode_i = OPC_ALU;
        fetch_rd_i     = 5'd0;
        fetch_rs1_i    = 5'd0;
        fetch_type_i   = TYPE_OTHER;
        fetch_imm_i    = 32'h0;
    endtask

    task automatic clear_train();
        ex_valid_i        = 1'b0;
        ex_is_jump_i      = 1'b0;
        ex_is_cond_br_i   = 1'b0;
        ex_is_jalr_i      = 1'b0;
        ex_taken_i        = 1'b0;
        ex_pred_correct_i = 1'b1;
        ex_pc_i           = 32'h0;
        ex_target_i       = 32'h0;
        ex_ghr_i          = '0;
        ex_lht_i          = '0;
        ex_gshare_taken_i = 1'b0;
        ex_local_taken_i  = 1'b0;
        ex_ras_sp_i       = '0;
        ex_ras_i          = '0;
    endtask

    // one fetch cycle with outputs sampled 1 ns after the falling edge
    task automatic present(input logic valid, input bp_isa_pkg::addr_t pc,
                           input logic [6:0] opcode, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [2:0] typ,
                           input logic [31:0] imm);
        @(negedge clk);
        clear_train();
        fetch_valid_i  = valid;
        fetch_pc_i     = pc;
        fetch_seq_pc_i = pc + 32'd4;
        fetch_opcode_i = opcode;
        fetch_rd_i     = rd;
        fetch_rs1_i    = rs1;
        fetch_type_i   = typ;
        fetch_imm_i    = imm;
        #1;
    endtask

    task automatic present_idle();
        @(negedge clk);
        clear_train();
        idle_fetch();
        #1;
    endtask

    // caller fills in the remaining ex_* fields in the same step
    task automatic start_train();
        @(negedge clk);
        idle_fetch();
        clear_train();
        ex_valid_i   = 1'b1;
        ex_is_jump_i = 1'b1;
    endtask

    task automatic check_pred(input logic exp_jump, input logic exp_taken,
                              input bp_isa_pkg::addr_t exp_pc);
        check_value("pred_is_jump_o", 256'(pred_is_jump_o), 256'(exp_jump));
        check_value("pred_taken_o", 256'(pred_taken_o), 256'(exp_taken));
        check_value("pred_pc_o", 256'(pred_pc_o), 256'(exp_pc));
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (rst) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic test_after_reset();
        present(1'b0, 32'h100, OPC_BRANCH, 5'd0, 5'd0, bp_isa_pkg::TYPE_B, 32'h40);
        check_pred(1'b1, 1'b0, 32'h104);
        present(1'b0, 32'h200, OPC_JAL, 5'd0, 5'd0, bp_isa_pkg::TYPE_J, 32'h80);
        check_pred(1'b1, 1'b1, 32'h280);
        present(1'b0, 32'h300, bp_isa_pkg::OP_SYSTEM, 5'd0, 5'd0, TYPE_OTHER, 32'h0);
        check_pred(1'b1, 1'b1, 32'h304);
        present(1'b0, 32'h340, OPC_ALU, 5'd3, 5'd4, TYPE_OTHER, 32'h0);
        check_pred(1'b0, 1'b0, 32'h344);
    endtask

    task automatic test_train_direction();
        start_train();
        ex_is_cond_br_i = 1'b1;
        ex_taken_i      = 1'b1;
        ex_pc_i         = 32'h100;
        ex_target_i     = 32'h140;
        present(1'b0, 32'h100, OPC_BRANCH, 5'd0, 5'd0, bp_isa_pkg::TYPE_B, 32'h40);
        check_pred(1'b1, 1'b1, 32'h140);
        check_value("snap_local_taken_o", 256'(snap_local_taken_o), 256'(1'b1));
        check_value("snap_gshare_taken_o", 256'(snap_gshare_taken_o), 256'(1'b1));
    endtask

    task automatic test_btb();
        present(1'b0, 32'h400, bp_isa_pkg::OP_JALR, 5'd0, 5'd6, TYPE_OTHER, 32'h10);
        check_pred(1'b1, 1'b1, 32'h404);
        start_train();
        ex_is_jalr_i = 1'b1;
        ex_pc_i      = 32'h400;
        ex_target_i  = 32'h1234_5678;
        present(1'b0, 32'h400, bp_isa_pkg::OP_JALR, 5'd0, 5'd6, TYPE_OTHER, 32'h10);
        check_pred(1'b1, 1'b1, 32'h1234_5678);
        // same index but another tag
        present(1'b0, 32'h1400, bp_isa_pkg::OP_JALR, 5'd0, 5'd6, TYPE_OTHER, 32'h10);
        check_pred(1'b1, 1'b1, 32'h1404);
    endtask

    task automatic test_ras();
        present(1'b1, 32'h500, OPC_JAL, bp_isa_pkg::REG_RA, 5'd0, bp_isa_pkg::TYPE_J, 32'h100);
        check_pred(1'b1, 1'b1, 32'h600);
        check_value("snap_ras_sp_o", 256'(snap_ras_sp_o), 256'(3'd1));
        present(1'b1, 32'h620, bp_isa_pkg::OP_JALR, bp_isa_pkg::REG_ZERO, bp_isa_pkg::REG_RA,
                TYPE_OTHER, 32'h0);
        check_pred(1'b1, 1'b1, 32'h504);
        check_value("snap_ras_sp_o", 256'(snap_ras_sp_o), 256'(3'd0));
        present(1'b0, 32'h640, bp_isa_pkg::OP_JALR, bp_isa_pkg::REG_ZERO, bp_isa_pkg::REG_RA,
                TYPE_OTHER, 32'h0);
        check_pred(1'b1, 1'b1, 32'h644);
    endtask

    task automatic test_rollback();
        logic [IDX_W-1:0]                  ghr_model;
        bp_isa_pkg::addr_t [RAS_DEPTH-1:0] ras_model;
        ghr_model = '0;
        present(1'b1, 32'h100, OPC_BRANCH, 5'd0, 5'd0, bp_isa_pkg::TYPE_B, 32'h40);
        check_pred(1'b1, 1'b1, 32'h140);
        check_value("snap_ghr_o", 256'(snap_ghr_o), 256'(ghr_model));
        ghr_model = shift_hist(ghr_model, 1'b1);
        present(1'b1, 32'h700, OPC_BRANCH, 5'd0, 5'd0, bp_isa_pkg::TYPE_B, 32'h20);
        check_pred(1'b1, 1'b0, 32'h704);
        check_value("snap_ghr_o", 256'(snap_ghr_o), 256'(ghr_model));
        ghr_model = shift_hist(ghr_model, 1'b0);

        // branch at 0x700 resolves taken after being predicted not taken
        start_train();
        ex_is_cond_br_i   = 1'b1;
        ex_taken_i        = 1'b1;
        ex_pred_correct_i = 1'b0;
        ex_pc_i           = 32'h700;
        ex_target_i       = 32'h720;
        ex_ghr_i          = 10'h2a5;
        ex_lht_i          = 10'h13c;
        #1;
        check_value("snap_ghr_o", 256'(snap_ghr_o), 256'(ghr_model));
        present_idle();
        check_value("snap_ghr_o", 256'(snap_ghr_o), 256'(shift_hist(10'h2a5, 1'b1)));
        present(1'b0, 32'h700, OPC_BRANCH, 5'd0, 5'd0, bp_isa_pkg::TYPE_B, 32'h20);
        check_value("snap_lht_o", 256'(snap_lht_o), 256'(shift_hist(10'h13c, 1'b1)));

        start_train();
        ex_pred_correct_i = 1'b0;
        ex_pc_i           = 32'h900;
        ex_target_i       = 32'ha00;
        ex_ras_sp_i       = 3'd3;
        for (int i = 0; i < RAS_DEPTH; i++) begin
            ex_ras_i[i] = $random(seed);
        end
        ras_model = ex_ras_i;
        present_idle();
        check_value("snap_ras_sp_o", 256'(snap_ras_sp_o), 256'(3'd3));
        check_value("snap_ras_o", 256'(snap_ras_o), 256'(ras_model));
        present(1'b0, 32'h660, bp_isa_pkg::OP_JALR, bp_isa_pkg::REG_ZERO, bp_isa_pkg::REG_T0,
                TYPE_OTHER, 32'h0);
        check_pred(1'b1, 1'b1, ras_model[2]);
    endtask

    initial begin
        error_count = 0;
        seed        = 32'h5e4b_6c21;
        idle_fetch();
        clear_train();
        wait_reset_release();

        test_after_reset();
        test_train_direction();
        test_btb();
        test_ras();
        test_rollback();

        present_idle();
        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// File: tests/branch_pred_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module branch_pred_assertions #(
    parameter int SP_W = 3
) (
    input logic              clk,
    input logic              rst,
    input logic              pred_is_jump_i,
    input logic              pred_taken_i,
    input bp_isa_pkg::addr_t pred_pc_i,
    input bp_isa_pkg::addr_t fetch_seq_pc_i,
    input logic [SP_W-1:0]   snap_ras_sp_i
);

    taken_needs_jump: assert property (@(posedge clk) disable iff (rst)
        pred_taken_i |-> pred_is_jump_i)
        else $error("taken predicted for an instruction that is not a jump");

    // non-jumps always fall through
    non_jump_seq_pc: assert property (@(posedge clk) disable iff (rst)
        !pred_is_jump_i |-> (pred_pc_i == fetch_seq_pc_i))
        else $error("non-jump predicted pc %h, sequential pc %h", pred_pc_i, fetch_seq_pc_i);

    ras_empty_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> (snap_ras_sp_i == '0))
        else $error("return stack pointer %h right after reset", snap_ras_sp_i);

endmodule

bind branch_pred branch_pred_assertions #(.SP_W(SP_W)) branch_pred_assertions_inst (
    .clk            (clk),
    .rst            (rst),
    .pred_is_jump_i (pred_is_jump_o),
    .pred_taken_i   (pred_taken_o),
    .pred_pc_i      (pred_pc_o),
    .fetch_seq_pc_i (fetch_seq_pc_i),
    .snap_ras_sp_i  (snap_ras_sp_o)
);

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

// 4 ns clock, reset held for the first two rising edges
module tb_clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/branch_pred.sv
`timescale 1ns/100ps
`default_nettype none

module branch_pred #(
    parameter int  IDX_W     = 10,
    parameter int  RAS_DEPTH = 8,
    localparam int SP_W      = $clog2(RAS_DEPTH)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetch_valid_i,
    input  bp_isa_pkg::addr_t                 fetch_pc_i,
    input  bp_isa_pkg::addr_t                 fetch_seq_pc_i,
    input  logic [6:0]                        fetch_opcode_i,
    input  logic [4:0]                        fetch_rd_i,
    input  logic [4:0]                        fetch_rs1_i,
    input  logic [2:0]                        fetch_type_i,
    input  logic [31:0]                       fetch_imm_i,
    output logic                              pred_is_jump_o,
    output logic                              pred_taken_o,
    output bp_isa_pkg::addr_t                 pred_pc_o,
    output logic [IDX_W-1:0]                  snap_ghr_o,
    output logic [IDX_W-1:0]                  snap_lht_o,
    output logic                              snap_gshare_taken_o,
    output logic                              snap_local_taken_o,
    output logic [SP_W-1:0]                   snap_ras_sp_o,
    output bp_isa_pkg::addr_t [RAS_DEPTH-1:0] snap_ras_o,
    input  logic                              ex_valid_i,
    input  logic                              ex_is_jump_i,
    input  logic                              ex_is_cond_br_i,
    input  logic                              ex_is_jalr_i,
    input  logic                              ex_taken_i,
    input  logic                              ex_pred_correct_i,
    input  bp_isa_pkg::addr_t                 ex_pc_i,
    input  bp_isa_pkg::addr_t                 ex_target_i,
    input  logic [IDX_W-1:0]                  ex_ghr_i,
    input  logic [IDX_W-1:0]                  ex_lht_i,
    input  logic                              ex_gshare_taken_i,
    input  logic                              ex_local_taken_i,
    input  logic [SP_W-1:0]                   ex_ras_sp_i,
    input  bp_isa_pkg::addr_t [RAS_DEPTH-1:0] ex_ras_i
);
    logic              dir_taken;
    bp_isa_pkg::addr_t ras_top;
    logic              ras_empty;
    logic              btb_hit;
    bp_isa_pkg::addr_t btb_target;

    fetch_class_if cls_if ();
    train_if #(.IDX_W(IDX_W), .RAS_DEPTH(RAS_DEPTH)) trn_if ();

    assign trn_if.valid        = ex_valid_i;
    assign trn_if.is_jump      = ex_is_jump_i;
    assign trn_if.is_cond_br   = ex_is_cond_br_i;
    assign trn_if.is_jalr      = ex_is_jalr_i;
    assign trn_if.taken        = ex_taken_i;
    assign trn_if.pred_correct = ex_pred_correct_i;
    assign trn_if.pc           = ex_pc_i;
    assign trn_if.target       = ex_target_i;
    assign trn_if.ghr          = ex_ghr_i;
    assign trn_if.lht          = ex_lht_i;
    assign trn_if.gshare_taken = ex_gshare_taken_i;
    assign trn_if.local_taken  = ex_local_taken_i;
    assign trn_if.ras_sp       = ex_ras_sp_i;
    assign trn_if.ras_snap     = ex_ras_i;

    next_pc_select next_pc_select_inst (
        .fetch_pc_i   (fetch_pc_i),
        .seq_pc_i     (fetch_seq_pc_i),
        .opcode_i     (fetch_opcode_i),
        .rd_i         (fetch_rd_i),
        .rs1_i        (fetch_rs1_i),
        .type_i       (fetch_type_i),
        .imm_i        (fetch_imm_i),
        .cls          (cls_if.src),
        .dir_taken_i  (dir_taken),
        .ras_top_i    (ras_top),
        .ras_empty_i  (ras_empty),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .is_jump_o    (pred_is_jump_o),
        .taken_o      (pred_taken_o),
        .pred_pc_o    (pred_pc_o)
    );

    tournament_dir #(.IDX_W(IDX_W)) tournament_dir_inst (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid_i  (fetch_valid_i),
        .cls            (cls_if.dst),
        .trn            (trn_if.dst),
        .taken_o        (dir_taken),
        .ghr_o          (snap_ghr_o),
        .lht_o          (snap_lht_o),
        .gshare_taken_o (snap_gshare_taken_o),
        .local_taken_o  (snap_local_taken_o)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) return_stack_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_valid_i (fetch_valid_i),
        .seq_pc_i      (fetch_seq_pc_i),
        .cls           (cls_if.dst),
        .trn           (trn_if.dst),
        .top_o         (ras_top),
        .empty_o       (ras_empty),
        .sp_next_o     (snap_ras_sp_o),
        .snap_o        (snap_ras_o)
    );

    jalr_btb #(.IDX_W(IDX_W)) jalr_btb_inst (
        .clk      (clk),
        .rst      (rst),
        .cls      (cls_if.dst),
        .trn      (trn_if.dst),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

endmodule

`default_nettype wire

// File: hdl/next_pc_select.sv
`timescale 1ns/100ps
`default_nettype none

module next_pc_select (
    input  bp_isa_pkg::addr_t fetch_pc_i,
    input  bp_isa_pkg::addr_t seq_pc_i,
    input  logic [6:0]        opcode_i,
    input  logic [4:0]        rd_i,
    input  logic [4:0]        rs1_i,
    input  logic [2:0]        type_i,
    input  logic [31:0]       imm_i,
    fetch_class_if.src        cls,
    input  logic              dir_taken_i,
    input  bp_isa_pkg::addr_t ras_top_i,
    input  logic              ras_empty_i,
    input  logic              btb_hit_i,
    input  bp_isa_pkg::addr_t btb_target_i,
    output logic              is_jump_o,
    output logic              taken_o,
    output bp_isa_pkg::addr_t pred_pc_o
);
    logic              is_system;
    logic              rd_link;
    logic              rs1_link;
    bp_isa_pkg::addr_t target;

    assign rd_link  = (rd_i == bp_isa_pkg::REG_RA) || (rd_i == bp_isa_pkg::REG_T0);
    assign rs1_link = (rs1_i == bp_isa_pkg::REG_RA) || (rs1_i == bp_isa_pkg::REG_T0);

    assign cls.fetch_pc   = fetch_pc_i;
    assign cls.is_cond_br = (type_i == bp_isa_pkg::TYPE_B);
    assign cls.is_jal     = (type_i == bp_isa_pkg::TYPE_J);
    assign cls.is_jalr    = (opcode_i == bp_isa_pkg::OP_JALR);
    assign is_system      = (opcode_i == bp_isa_pkg::OP_SYSTEM);
    assign cls.is_call    = (cls.is_jal || cls.is_jalr) && rd_link;
    assign cls.is_ret     = cls.is_jalr && (rd_i == bp_isa_pkg::REG_ZERO) && rs1_link &&
                            (imm_i == '0);

    assign is_jump_o = cls.is_cond_br || cls.is_jal || cls.is_jalr || is_system;
    assign taken_o   = cls.is_cond_br ? dir_taken_i : is_jump_o;

    // target priority: pc-relative, ras, btb
    always_comb begin
        if (cls.is_cond_br || cls.is_jal) begin
            target = fetch_pc_i + imm_i;
        end else if (cls.is_ret && !ras_empty_i) begin
            target = ras_top_i;
        end else if (cls.is_jalr && btb_hit_i) begin
            target = btb_target_i;
        end else begin
            target = seq_pc_i;
        end
    end

    assign pred_pc_o = taken_o ? target : seq_pc_i;

endmodule

`default_nettype wire

// File: hdl/jalr_btb.sv
`timescale 1ns/100ps
`default_nettype none

module jalr_btb #(
    parameter int IDX_W = 10
) (
    input  logic              clk,
    input  logic              rst,
    fetch_class_if.dst        cls,
    train_if.dst              trn,
    output logic              hit_o,
    output bp_isa_pkg::addr_t target_o
);
    localparam int ENTRIES = 1 << IDX_W;

    bp_isa_pkg::addr_t tags [ENTRIES];
    bp_isa_pkg::addr_t targets [ENTRIES];
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  t_idx;

    assign idx      = cls.fetch_pc[IDX_W+1:2];
    // full pc tag, no aliasing between same-index jumps
    assign hit_o    = (tags[idx] == cls.fetch_pc);
    assign target_o = targets[idx];
    assign t_idx    = trn.pc[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ENTRIES; i++) begin
                tags[i]    <= '0;
                targets[i] <= '0;
            end
        end else if (trn.valid && trn.is_jump && trn.is_jalr) begin
            tags[t_idx]    <= trn.pc;
            targets[t_idx] <= trn.target;
        end
    end

endmodule

`default_nettype wire

// File: hdl/return_stack.sv
`timescale 1ns/100ps
`default_nettype none

module return_stack #(
    parameter int  RAS_DEPTH = 8,
    localparam int SP_W      = $clog2(RAS_DEPTH)
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fetch_valid_i,
    input  bp_isa_pkg::addr_t                 seq_pc_i,
    fetch_class_if.dst                        cls,
    train_if.dst                              trn,
    output bp_isa_pkg::addr_t                 top_o,
    output logic                              empty_o,
    output logic [SP_W-1:0]                   sp_next_o,
    output bp_isa_pkg::addr_t [RAS_DEPTH-1:0] snap_o
);
    bp_isa_pkg::addr_t [RAS_DEPTH-1:0] stack;
    logic [SP_W-1:0]                   sp;
    logic                              restore;

    assign empty_o = (sp == '0);
    assign top_o   = empty_o ? '0 : stack[sp - 1'b1];

    always_comb begin
        if (cls.is_call) begin
            sp_next_o = sp + 1'b1;
        end else if (cls.is_ret && !empty_o) begin
            sp_next_o = sp - 1'b1;
        end else begin
            sp_next_o = sp;
        end
    end

    // snapshot includes the push of this call
    always_comb begin
        snap_o = stack;
        if (fetch_valid_i && cls.is_call) begin
            snap_o[sp] = seq_pc_i;
        end
    end

    assign restore = trn.valid && trn.is_jump && !trn.pred_correct;

    always_ff @(posedge clk) begin
        if (rst) begin
            sp    <= '0;
            stack <= '0;
        end else if (restore) begin
            sp    <= trn.ras_sp;
            stack <= trn.ras_snap;
        end else if (fetch_valid_i) begin
            if (cls.is_call) begin
                stack[sp] <= seq_pc_i;
                sp        <= sp + 1'b1;
            end else if (cls.is_ret && !empty_o) begin
                sp <= sp - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/tournament_dir.sv
`timescale 1ns/100ps
`default_nettype none

module tournament_dir #(
    parameter int IDX_W = 10
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_valid_i,
    fetch_class_if.dst       cls,
    train_if.dst             trn,
    output logic             taken_o,
    output logic [IDX_W-1:0] ghr_o,
    output logic [IDX_W-1:0] lht_o,
    output logic             gshare_taken_o,
    output logic             local_taken_o
);
    localparam int ENTRIES = 1 << IDX_W;

    logic [IDX_W-1:0]  ghr;
    logic [IDX_W-1:0]  lht [ENTRIES];
    bp_cfg_pkg::ctr2_t pht [ENTRIES];
    bp_cfg_pkg::ctr2_t lpht [ENTRIES];
    bp_cfg_pkg::ctr2_t chooser [ENTRIES];

    logic [IDX_W-1:0] pc_idx;
    logic [IDX_W-1:0] g_idx;
    logic [IDX_W-1:0] l_idx;
    logic [IDX_W-1:0] t_idx;
    logic             trn_cond;
    logic             rollback;
    logic             local_won;
    logic             gshare_won;

    // fetch side lookup
    assign pc_idx = cls.fetch_pc[IDX_W+1:2];
    assign lht_o  = lht[pc_idx];
    assign g_idx  = pc_idx ^ ghr;
    assign l_idx  = pc_idx ^ lht_o;

    assign gshare_taken_o = pht[g_idx][1];
    assign local_taken_o  = lpht[l_idx][1];
    assign taken_o        = chooser[pc_idx][1] ? local_taken_o : gshare_taken_o;
    assign ghr_o          = ghr;

    // execute side
    assign t_idx      = trn.pc[IDX_W+1:2];
    assign trn_cond   = trn.valid && trn.is_jump && trn.is_cond_br;
    assign rollback   = trn_cond && !trn.pred_correct;
    assign local_won  = (trn.local_taken == trn.taken) && (trn.gshare_taken != trn.taken);
    assign gshare_won = (trn.gshare_taken == trn.taken) && (trn.local_taken != trn.taken);

    always_ff @(posedge clk) begin
        if (rst) begin
            ghr <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                lht[i]     <= '0;
                pht[i]     <= bp_cfg_pkg::CTR_WEAK_NT;
                lpht[i]    <= bp_cfg_pkg::CTR_WEAK_NT;
                chooser[i] <= bp_cfg_pkg::CTR_WEAK_LOCAL;
            end
        end else begin
            // history repair wins over speculative shift
            if (rollback) begin
                ghr        <= {trn.ghr[IDX_W-2:0], trn.taken};
                lht[t_idx] <= {trn.lht[IDX_W-2:0], trn.taken};
            end else if (fetch_valid_i && cls.is_cond_br) begin
                ghr         <= {ghr[IDX_W-2:0], taken_o};
                lht[pc_idx] <= {lht_o[IDX_W-2:0], taken_o};
            end

            if (trn_cond) begin
                pht[t_idx ^ trn.ghr] <=
                    bp_cfg_pkg::ctr_update(pht[t_idx ^ trn.ghr], trn.taken);
                lpht[t_idx ^ trn.lht] <=
                    bp_cfg_pkg::ctr_update(lpht[t_idx ^ trn.lht], trn.taken);
                if (local_won || gshare_won) begin
                    chooser[t_idx] <= bp_cfg_pkg::ctr_update(chooser[t_idx], local_won);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bp_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// decoded class of the instruction in fetch
interface fetch_class_if;
    logic              is_cond_br;
    logic              is_jal;
    logic              is_jalr;
    logic              is_call;
    logic              is_ret;
    bp_isa_pkg::addr_t fetch_pc;

    modport src (output is_cond_br, is_jal, is_jalr, is_call, is_ret, fetch_pc);
    modport dst (input  is_cond_br, is_jal, is_jalr, is_call, is_ret, fetch_pc);
endinterface

// resolved branch info coming back from execute
interface train_if #(
    parameter int IDX_W     = 10,
    parameter int RAS_DEPTH = 8
);
    localparam int SP_W = $clog2(RAS_DEPTH);

    logic                                  valid;
    logic                                  is_jump;
    logic                                  is_cond_br;
    logic                                  is_jalr;
    logic                                  taken;
    logic                                  pred_correct;
    bp_isa_pkg::addr_t                     pc;
    bp_isa_pkg::addr_t                     target;
    logic [IDX_W-1:0]                      ghr;
    logic [IDX_W-1:0]                      lht;
    logic                                  gshare_taken;
    logic                                  local_taken;
    logic [SP_W-1:0]                       ras_sp;
    bp_isa_pkg::addr_t [RAS_DEPTH-1:0]     ras_snap;

    modport src (output valid, is_jump, is_cond_br, is_jalr, taken, pred_correct, pc, target,
                        ghr, lht, gshare_taken, local_taken, ras_sp, ras_snap);
    modport dst (input  valid, is_jump, is_cond_br, is_jalr, taken, pred_correct, pc, target,
                        ghr, lht, gshare_taken, local_taken, ras_sp, ras_snap);
endinterface

`default_nettype wire

// File: hdl/bp_cfg_pkg.sv
`default_nettype none

package bp_cfg_pkg;

    typedef logic [1:0] ctr2_t;

    localparam ctr2_t CTR_MIN        = 2'b00;
    localparam ctr2_t CTR_WEAK_NT    = 2'b01;
    localparam ctr2_t CTR_WEAK_LOCAL = 2'b10;
    localparam ctr2_t CTR_MAX        = 2'b11;

    // saturating step, msb is the decision bit
    function automatic ctr2_t ctr_update(input ctr2_t ctr, input logic up);
        ctr2_t result;
        if (up) begin
            result = (ctr == CTR_MAX) ? ctr : ctr + 2'd1;
        end else begin
            result = (ctr == CTR_MIN) ? ctr : ctr - 2'd1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

// File: hdl/bp_isa_pkg.sv
`default_nettype none

package bp_isa_pkg;

    typedef logic [31:0] addr_t;

    // major opcodes seen by the predictor
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // decoder instruction-type codes
    localparam logic [2:0] TYPE_B = 3'b011;
    localparam logic [2:0] TYPE_J = 3'b101;

    // link registers for call/return detection
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_T0   = 5'd5;

endpackage

`default_nettype wire
